// File: testbench/program.hex
// one instruction word per line, loaded at the boot vector
// covers alu ops, load-use, sw/sb lanes, beq/bne, jal, jr, final jump to self
3c011234
34215678
24020040
8c430000
00612021
ac440004
a0410008
a0440009
a043000a
a041000b
8c450008
90460005
00a63823
10e70002
00074100
240a0001
15080003
0ff00015
000848c2
0bf00013
00000000
01235826
03e00008
0164602b

// File: mips_core.f
+incdir+design
design/mips_isa_pkg.sv
design/mips_pipe_pkg.sv
design/fetch_decode.sv
design/execute_stage.sv
design/writeback_stage.sv
design/reg_file.sv
design/mips_core.sv
testbench/tb_sram.sv
testbench/mips_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     = --timing --assert
TOP       = mips_core_tb
DUT_TOP   = mips_core
FILELIST  = mips_core.f
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_bin
	-./obj_dir/sim_bin | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/mips_core_tb.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module mips_core_tb;
	import mips_pipe_pkg::*;

	localparam int PROG_LEN = 24;
	localparam int WATCHDOG_CYCLES = 3 + 4 * PROG_LEN + 40;

	logic clk;
	logic resetn;
	imem_req_t imem_req;
	logic [`XLEN-1:0] imem_rdata;
	dmem_req_t dmem_req;
	logic [`XLEN-1:0] dmem_rdata;
	wb_trace_t trace;

	// reference model state
	logic [31:0] model_rom [0:63];
	logic [31:0] model_ram [0:255];
	logic [31:0] model_regs [0:31];
	// expected register writes, in program order
	logic [31:0] exp_pc [$];
	logic [4:0] exp_num [$];
	logic [31:0] exp_val [$];
	// expected stores
	logic [31:0] exp_st_addr [$];
	logic [3:0] exp_st_wen [$];
	logic [31:0] exp_st_data [$];
	logic writes_done;
	logic prev_resetn;
	int reset_edges;

	mips_core mips_core_inst (
		.clk(clk),
		.resetn(resetn),
		.imem_req(imem_req),
		.imem_rdata(imem_rdata),
		.dmem_req(dmem_req),
		.dmem_rdata(dmem_rdata),
		.trace(trace)
	);

	tb_sram sram_inst (
		.clk(clk),
		.imem_req(imem_req),
		.imem_rdata(imem_rdata),
		.dmem_req(dmem_req),
		.dmem_rdata(dmem_rdata)
	);

	always #5 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic value_error(input string what);
		abort_run($sformatf("ERROR at %0t ns: %s", $time, what));
	endtask

	function automatic logic [31:0] lane_mask(input logic [3:0] wen);
		return {{8{wen[3]}}, {8{wen[2]}}, {8{wen[1]}}, {8{wen[0]}}};
	endfunction

	// instruction-level model, one delay slot, stops at a jump to itself
	task automatic build_expected();
		logic [31:0] pc, npc, cur, ins, rsv, rtv, res, addr, tgt, simm, zimm;
		logic [4:0] rs, rt, rd, dst, sa;
		logic [1:0] lane;
		logic wr, br, stop;
		int steps;
		pc = `BOOT_VECTOR;
		npc = `BOOT_VECTOR + 32'd4;
		stop = 1'b0;
		steps = 0;
		for (int r = 0; r < 32; r++)
			model_regs[r] = '0;
		while (!stop && steps < 1000)
		begin
			cur = pc;
			ins = model_rom[cur[7:2]];
			pc = npc;
			npc = pc + 32'd4;
			rs = ins[25:21];
			rt = ins[20:16];
			rd = ins[15:11];
			sa = ins[10:6];
			rsv = model_regs[rs];
			rtv = model_regs[rt];
			simm = {{16{ins[15]}}, ins[15:0]};
			zimm = {16'b0, ins[15:0]};
			addr = rsv + simm;
			lane = addr[1:0];
			wr = 1'b0;
			br = 1'b0;
			dst = rt;
			res = '0;
			tgt = '0;
			case (ins[31:26])
				6'h00:
				begin
					dst = rd;
					wr = 1'b1;
					case (ins[5:0])
						6'h00: res = rtv << sa;
						6'h02: res = rtv >> sa;
						6'h08:
						begin
							wr = 1'b0;
							br = 1'b1;
							tgt = rsv;
						end
						6'h21: res = rsv + rtv;
						6'h23: res = rsv - rtv;
						6'h24: res = rsv & rtv;
						6'h25: res = rsv | rtv;
						6'h26: res = rsv ^ rtv;
						6'h2a: res = {31'b0, $signed(rsv) < $signed(rtv)};
						6'h2b: res = {31'b0, rsv < rtv};
						default: wr = 1'b0;
					endcase
				end
				6'h02, 6'h03:
				begin
					br = 1'b1;
					// pc already holds the delay slot address
					tgt = {pc[31:28], ins[25:0], 2'b00};
					stop = (tgt == cur);
					if (ins[26])
					begin
						wr = 1'b1;
						dst = 5'd31;
						res = cur + 32'd8;
					end
				end
				6'h04:
				begin
					br = (rsv == rtv);
					tgt = pc + (simm << 2);
				end
				6'h05:
				begin
					br = (rsv != rtv);
					tgt = pc + (simm << 2);
				end
				6'h09: {wr, res} = {1'b1, rsv + simm};
				6'h0a: {wr, res} = {1'b1, 31'b0, $signed(rsv) < $signed(simm)};
				6'h0c: {wr, res} = {1'b1, rsv & zimm};
				6'h0d: {wr, res} = {1'b1, rsv | zimm};
				6'h0f: {wr, res} = {1'b1, ins[15:0], 16'b0};
				6'h23: {wr, res} = {1'b1, model_ram[addr[9:2]]};
				6'h24: {wr, res} = {1'b1, 24'b0, model_ram[addr[9:2]][lane*8 +: 8]};
				6'h2b:
				begin
					model_ram[addr[9:2]] = rtv;
					exp_st_addr.push_back(addr);
					exp_st_wen.push_back(4'b1111);
					exp_st_data.push_back(rtv);
				end
				6'h28:
				begin
					model_ram[addr[9:2]][lane*8 +: 8] = rtv[7:0];
					exp_st_addr.push_back(addr);
					exp_st_wen.push_back(4'b0001 << lane);
					exp_st_data.push_back({4{rtv[7:0]}});
				end
				default: wr = 1'b0;
			endcase
			// r0 stays zero and never shows in the trace
			if (wr && dst != 5'd0)
			begin
				model_regs[dst] = res;
				exp_pc.push_back(cur);
				exp_num.push_back(dst);
				exp_val.push_back(res);
			end
			if (br)
				npc = tgt;
			steps++;
		end
		if (!stop)
			abort_run("reference model found no final jump to itself");
	endtask

	// reset values and the first fetch
	always @(posedge clk)
	begin
		if (!resetn)
		begin
			if (reset_edges > 0)
				assert (trace.wen == 4'b0 && !dmem_req.en && dmem_req.wen == 4'b0)
				else value_error("trace or data request active during reset");
			reset_edges <= reset_edges + 1;
		end
		else if (!prev_resetn)
		begin
			assert (trace.wen == 4'b0 && !dmem_req.en && dmem_req.wen == 4'b0)
			else value_error("trace or data request active just after reset");
			assert (imem_req.en && imem_req.addr == `BOOT_VECTOR)
			else value_error($sformatf("first fetch at %h", imem_req.addr));
		end
		prev_resetn <= resetn;
	end

	// register writes in model order, lanes all set together
	always @(posedge clk)
	begin
		if (resetn && trace.wen != 4'b0000)
		begin
			if (exp_pc.size() == 0)
				abort_run("register write seen after the last expected one");
			else
			begin
				assert (trace.wen == 4'b1111 && trace.pc == exp_pc[0] &&
					trace.wnum == exp_num[0] && trace.wdata == exp_val[0])
				else value_error($sformatf("write pc %h wen %b r%0d = %h, expected %h r%0d = %h",
					trace.pc, trace.wen, trace.wnum, trace.wdata,
					exp_pc[0], exp_num[0], exp_val[0]));
				void'(exp_pc.pop_front());
				void'(exp_num.pop_front());
				void'(exp_val.pop_front());
				if (exp_pc.size() == 0)
					writes_done <= 1'b1;
			end
		end
	end

	// store lanes and data
	always @(posedge clk)
	begin
		if (resetn && dmem_req.wen != 4'b0)
		begin
			if (exp_st_addr.size() == 0)
				abort_run("store seen that the program does not make");
			else
			begin
				assert (dmem_req.en && dmem_req.addr == exp_st_addr[0] &&
					dmem_req.wen == exp_st_wen[0] &&
					(dmem_req.wdata & lane_mask(exp_st_wen[0])) ==
					(exp_st_data[0] & lane_mask(exp_st_wen[0])))
				else value_error($sformatf("store %h wen %b data %h, expected %h wen %b data %h",
					dmem_req.addr, dmem_req.wen, dmem_req.wdata,
					exp_st_addr[0], exp_st_wen[0], exp_st_data[0]));
				void'(exp_st_addr.pop_front());
				void'(exp_st_wen.pop_front());
				void'(exp_st_data.pop_front());
			end
		end
	end

	assert property (@(posedge clk) disable iff (!resetn)
		trace.wen != 4'b0 |-> trace.wnum != 5'd0)
	else abort_run("trace shows a write to register 0");

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("program did not reach its end before the cycle limit");
	end

	initial
	begin
		logic [31:0] v;
		clk = 1'b0;
		resetn = 1'b0;
		writes_done = 1'b0;
		prev_resetn = 1'b0;
		reset_edges = 0;
		v = $urandom(56192);
		for (int i = 0; i < 256; i++)
		begin
			v = $urandom();
			sram_inst.dram[i] = v;
			model_ram[i] = v;
		end
		for (int i = 0; i < 64; i++)
			model_rom[i] = '0;
		$readmemh("testbench/program.hex", model_rom);
		build_expected();
		repeat (3) @(posedge clk);
		#1 resetn = 1'b1;
		wait (writes_done);
		// final jump's delay slot still reaches the trace
		repeat (4) @(posedge clk);
		if (exp_st_addr.size() == 0)
		begin
			$display("Everything OK");
			$finish;
		end
		else
			abort_run("not all expected stores were seen");
	end

endmodule

// File: testbench/tb_sram.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module tb_sram (
	input logic clk,
	input mips_pipe_pkg::imem_req_t imem_req,
	output logic [`XLEN-1:0] imem_rdata,
	input mips_pipe_pkg::dmem_req_t dmem_req,
	output logic [`XLEN-1:0] dmem_rdata
);
	import mips_pipe_pkg::*;

	// 64-word program ROM and 256-word data RAM
	logic [`XLEN-1:0] rom [0:63];
	logic [`XLEN-1:0] dram [0:255];
	logic [7:0] dram_idx;
	integer i;

	assign dram_idx = dmem_req.addr[9:2];

	initial
	begin
		// words past the program read as nop
		for (i = 0; i < 64; i = i + 1)
			rom[i] = '0;
		$readmemh("testbench/program.hex", rom);
		imem_rdata = '0;
		dmem_rdata = '0;
	end

	// one cycle read latency
	always @(posedge clk)
	begin
		if (imem_req.en)
			imem_rdata <= rom[imem_req.addr[7:2]];
	end

	// byte lanes written only where wen is set
	always @(posedge clk)
	begin
		if (dmem_req.en)
		begin
			dmem_rdata <= dram[dram_idx];
			for (int lane = 0; lane < 4; lane++)
			begin
				if (dmem_req.wen[lane])
					dram[dram_idx][lane*8 +: 8] <= dmem_req.wdata[lane*8 +: 8];
			end
		end
	end

endmodule

// File: design/mips_core.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module mips_core (
	input logic clk,
	input logic resetn,
	output mips_pipe_pkg::imem_req_t imem_req,
	input logic [`XLEN-1:0] imem_rdata,
	output mips_pipe_pkg::dmem_req_t dmem_req,
	input logic [`XLEN-1:0] dmem_rdata,
	output mips_pipe_pkg::wb_trace_t trace
);
	import mips_pipe_pkg::*;

	// ID -> EX
	id_ex_t id_ex;
	logic id_ex_valid;
	// EX -> MEM
	ex_mem_t ex_mem;
	logic ex_mem_valid;
	// MEM write, also the EX bypass
	rf_write_t rf_write;
	// branch resolution back to fetch
	logic redirect;
	logic [`XLEN-1:0] redirect_pc;
	logic [4:0] rs_addr;
	logic [4:0] rt_addr;
	logic [`XLEN-1:0] rs_data;
	logic [`XLEN-1:0] rt_data;

	fetch_decode fetch_decode_inst (
		.clk(clk),
		.resetn(resetn),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.imem_req(imem_req),
		.imem_rdata(imem_rdata),
		.id_ex(id_ex),
		.id_ex_valid(id_ex_valid)
	);

	execute_stage execute_stage_inst (
		.clk(clk),
		.resetn(resetn),
		.id_ex(id_ex),
		.id_ex_valid(id_ex_valid),
		.rs_addr(rs_addr),
		.rt_addr(rt_addr),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.fwd(rf_write),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.dmem_req(dmem_req),
		.ex_mem(ex_mem),
		.ex_mem_valid(ex_mem_valid)
	);

	writeback_stage writeback_stage_inst (
		.clk(clk),
		.resetn(resetn),
		.ex_mem(ex_mem),
		.ex_mem_valid(ex_mem_valid),
		.dmem_rdata(dmem_rdata),
		.rf_write(rf_write),
		.trace(trace)
	);

	reg_file reg_file_inst (
		.clk(clk),
		.rs_addr(rs_addr),
		.rt_addr(rt_addr),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.wr(rf_write)
	);

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module reg_file (
	input logic clk,
	input logic [4:0] rs_addr,
	input logic [4:0] rt_addr,
	output logic [`XLEN-1:0] rs_data,
	output logic [`XLEN-1:0] rt_data,
	input mips_pipe_pkg::rf_write_t wr
);

	logic [`XLEN-1:0] regs [`NREGS];

	// async reads, r0 hardwired to zero
	assign rs_data = (rs_addr == 5'd0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == 5'd0) ? '0 : regs[rt_addr];

	always_ff @(posedge clk)
	begin
		if (wr.en)
			regs[wr.addr] <= wr.data;
	end

	// writeback filters r0 before it gets here
	assert property (@(posedge clk) wr.en |-> wr.addr != 5'd0);

endmodule

// File: design/writeback_stage.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module writeback_stage (
	input logic clk,
	input logic resetn,
	input mips_pipe_pkg::ex_mem_t ex_mem,
	input logic ex_mem_valid,
	input logic [`XLEN-1:0] dmem_rdata,
	output mips_pipe_pkg::rf_write_t rf_write,
	output mips_pipe_pkg::wb_trace_t trace
);
	import mips_pipe_pkg::*;

	logic [7:0] load_byte;
	logic [`XLEN-1:0] wdata;

	// lbu lane picked by address low bits
	assign load_byte = dmem_rdata[{ex_mem.alu_res[1:0], 3'b000} +: 8];

	always_comb
	begin
		case (ex_mem.wb_sel)
			WB_LW: wdata = dmem_rdata;
			WB_LBU: wdata = {24'b0, load_byte};
			WB_LINK: wdata = ex_mem.link_addr;
			default: wdata = ex_mem.alu_res;
		endcase
	end

	// r0 writes dropped here, so forwarding never sees them
	assign rf_write.en = ex_mem_valid && ex_mem.reg_write && (ex_mem.dst != 5'd0);
	assign rf_write.addr = ex_mem.dst;
	assign rf_write.data = wdata;

	// trace lags the register write by one cycle
	always_ff @(posedge clk)
	begin
		if (!resetn)
			trace.wen <= 4'b0000;
		else
			trace.wen <= {4{rf_write.en}};
		trace.pc <= ex_mem.pc;
		trace.wnum <= rf_write.addr;
		trace.wdata <= rf_write.data;
	end

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module execute_stage (
	input logic clk,
	input logic resetn,
	input mips_pipe_pkg::id_ex_t id_ex,
	input logic id_ex_valid,
	output logic [4:0] rs_addr,
	output logic [4:0] rt_addr,
	input logic [`XLEN-1:0] rs_data,
	input logic [`XLEN-1:0] rt_data,
	input mips_pipe_pkg::rf_write_t fwd,
	output logic redirect,
	output logic [`XLEN-1:0] redirect_pc,
	output mips_pipe_pkg::dmem_req_t dmem_req,
	output mips_pipe_pkg::ex_mem_t ex_mem,
	output logic ex_mem_valid
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	logic [`XLEN-1:0] rs_val;
	logic [`XLEN-1:0] rt_val;
	logic [`XLEN-1:0] simm;
	logic [`XLEN-1:0] zimm;
	logic [`XLEN-1:0] a;
	logic [`XLEN-1:0] b;
	logic [`XLEN-1:0] alu_res;
	logic [`XLEN-1:0] slot_pc;
	logic taken;
	logic [3:0] sb_wen;

	assign rs_addr = id_ex.instr.r_fmt.rs;
	assign rt_addr = id_ex.instr.r_fmt.rt;

	// bypass the value being written this cycle
	// covers load-use too since load data is back in MEM
	assign rs_val = (fwd.en && fwd.addr == rs_addr) ? fwd.data : rs_data;
	assign rt_val = (fwd.en && fwd.addr == rt_addr) ? fwd.data : rt_data;

	assign simm = {{16{id_ex.instr.i_fmt.imm16[15]}}, id_ex.instr.i_fmt.imm16};
	assign zimm = {16'b0, id_ex.instr.i_fmt.imm16};

	// shifts take the amount in a, the value in b
	assign a = id_ex.shamt_sel ? {27'b0, id_ex.instr.r_fmt.shamt} : rs_val;

	always_comb
	begin
		case (id_ex.b_src)
			B_SIMM: b = simm;
			B_ZIMM: b = zimm;
			default: b = rt_val;
		endcase
	end

	always_comb
	begin
		case (id_ex.alu_op)
			ALU_SUB: alu_res = a - b;
			ALU_AND: alu_res = a & b;
			ALU_OR: alu_res = a | b;
			ALU_XOR: alu_res = a ^ b;
			ALU_SLT: alu_res = {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU: alu_res = {31'b0, a < b};
			ALU_SLL: alu_res = b << a[4:0];
			ALU_SRL: alu_res = b >> a[4:0];
			ALU_LUI: alu_res = {b[15:0], 16'b0};
			default: alu_res = a + b;
		endcase
	end

	// targets are relative to the delay slot
	assign slot_pc = id_ex.pc + 32'd4;

	always_comb
	begin
		taken = 1'b0;
		redirect_pc = slot_pc + {simm[29:0], 2'b00};
		case (id_ex.branch)
			BR_BEQ: taken = (rs_val == rt_val);
			BR_BNE: taken = (rs_val != rt_val);
			BR_J:
			begin
				taken = 1'b1;
				redirect_pc = {slot_pc[31:28], id_ex.instr.j_fmt.target26, 2'b00};
			end
			BR_JR:
			begin
				taken = 1'b1;
				redirect_pc = rs_val;
			end
			default: taken = 1'b0;
		endcase
	end

	// delay slot in ID still completes, only the next fetch changes
	assign redirect = id_ex_valid && taken;

	// byte lane from the low address bits
	assign sb_wen = 4'b0001 << alu_res[1:0];

	assign dmem_req.en = id_ex_valid && (id_ex.mem_read || id_ex.store_word || id_ex.store_byte);
	assign dmem_req.wen = !id_ex_valid ? 4'b0000 :
		id_ex.store_word ? 4'b1111 :
		id_ex.store_byte ? sb_wen : 4'b0000;
	assign dmem_req.addr = alu_res;
	// sb puts the byte on every lane, wen picks one
	assign dmem_req.wdata = id_ex.store_byte ? {4{rt_val[7:0]}} : rt_val;

	always_ff @(posedge clk)
	begin
		if (!resetn)
			ex_mem_valid <= 1'b0;
		else
			ex_mem_valid <= id_ex_valid;
		ex_mem.pc <= id_ex.pc;
		ex_mem.alu_res <= alu_res;
		ex_mem.rt_val <= rt_val;
		ex_mem.reg_write <= id_ex.reg_write;
		ex_mem.wb_sel <= id_ex.wb_sel;
		ex_mem.dst <= id_ex.dst;
		// return address skips the delay slot
		ex_mem.link_addr <= slot_pc + 32'd4;
	end

	// decode never flags one access as both load and store
	assert property (@(posedge clk) disable iff (!resetn)
		id_ex_valid |-> !(id_ex.mem_read && (id_ex.store_word || id_ex.store_byte)));

endmodule

// File: design/fetch_decode.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module fetch_decode (
	input logic clk,
	input logic resetn,
	input logic redirect,
	input logic [`XLEN-1:0] redirect_pc,
	output mips_pipe_pkg::imem_req_t imem_req,
	input logic [`XLEN-1:0] imem_rdata,
	output mips_pipe_pkg::id_ex_t id_ex,
	output logic id_ex_valid
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	// pc of the word now returning from the instruction sram
	logic [`XLEN-1:0] id_pc;
	logic id_valid;
	instr_u instr;
	id_ex_t dec;

	// fetch never stalls
	assign imem_req.en = 1'b1;
	// id_valid low right after reset, so boot vector goes out first
	assign imem_req.addr = redirect ? redirect_pc : (id_valid ? id_pc + 32'd4 : id_pc);

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			id_pc <= `BOOT_VECTOR;
			id_valid <= 1'b0;
		end
		else
		begin
			id_pc <= imem_req.addr;
			id_valid <= 1'b1;
		end
	end

	assign instr = imem_rdata;

	always_comb
	begin
		dec = '0;
		dec.pc = id_pc;
		dec.instr = instr;
		dec.alu_op = ALU_ADD;
		dec.b_src = B_SIMM;
		dec.branch = BR_NONE;
		dec.wb_sel = WB_ALU;
		// i-type writes rt by default
		dec.dst = instr.i_fmt.rt;
		case (instr.r_fmt.opcode)
			OP_SPECIAL:
			begin
				dec.b_src = B_REG;
				dec.dst = instr.r_fmt.rd;
				dec.reg_write = 1'b1;
				case (instr.r_fmt.funct)
					FN_ADDU: dec.alu_op = ALU_ADD;
					FN_SUBU: dec.alu_op = ALU_SUB;
					FN_AND: dec.alu_op = ALU_AND;
					FN_OR: dec.alu_op = ALU_OR;
					FN_XOR: dec.alu_op = ALU_XOR;
					FN_SLT: dec.alu_op = ALU_SLT;
					FN_SLTU: dec.alu_op = ALU_SLTU;
					FN_SLL:
					begin
						dec.alu_op = ALU_SLL;
						dec.shamt_sel = 1'b1;
					end
					FN_SRL:
					begin
						dec.alu_op = ALU_SRL;
						dec.shamt_sel = 1'b1;
					end
					FN_JR:
					begin
						dec.branch = BR_JR;
						dec.reg_write = 1'b0;
					end
					// unknown funct acts as nop
					default: dec.reg_write = 1'b0;
				endcase
			end
			OP_J: dec.branch = BR_J;
			OP_JAL:
			begin
				dec.branch = BR_J;
				dec.reg_write = 1'b1;
				dec.wb_sel = WB_LINK;
				dec.dst = `LINK_REG;
			end
			// compare done on forwarded operands in EX
			OP_BEQ: dec.branch = BR_BEQ;
			OP_BNE: dec.branch = BR_BNE;
			OP_ADDIU: dec.reg_write = 1'b1;
			OP_SLTI:
			begin
				dec.alu_op = ALU_SLT;
				dec.reg_write = 1'b1;
			end
			OP_ANDI:
			begin
				dec.alu_op = ALU_AND;
				dec.b_src = B_ZIMM;
				dec.reg_write = 1'b1;
			end
			OP_ORI:
			begin
				dec.alu_op = ALU_OR;
				dec.b_src = B_ZIMM;
				dec.reg_write = 1'b1;
			end
			OP_LUI:
			begin
				dec.alu_op = ALU_LUI;
				dec.b_src = B_ZIMM;
				dec.reg_write = 1'b1;
			end
			// loads and stores use base plus signed offset
			OP_LW:
			begin
				dec.mem_read = 1'b1;
				dec.reg_write = 1'b1;
				dec.wb_sel = WB_LW;
			end
			OP_LBU:
			begin
				dec.mem_read = 1'b1;
				dec.reg_write = 1'b1;
				dec.wb_sel = WB_LBU;
			end
			OP_SW: dec.store_word = 1'b1;
			OP_SB: dec.store_byte = 1'b1;
			default: dec.reg_write = 1'b0;
		endcase
	end

	// ID/EX register, payload has no reset
	always_ff @(posedge clk)
	begin
		if (!resetn)
			id_ex_valid <= 1'b0;
		else
			id_ex_valid <= id_valid;
		id_ex <= dec;
	end

endmodule

// File: design/mips_pipe_pkg.sv
`include "cpu_params.svh"

package mips_pipe_pkg;

	// alu operand b source
	typedef enum logic [1:0] {
		B_REG,
		B_SIMM,
		B_ZIMM
	} b_src_e;

	// register write value source
	typedef enum logic [1:0] {
		WB_ALU,
		WB_LW,
		WB_LBU,
		WB_LINK
	} wb_sel_e;

	// control transfer kind, jal is BR_J plus a link write
	typedef enum logic [2:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_J,
		BR_JR
	} branch_e;

	// decoded instruction entering EX
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		mips_isa_pkg::instr_u instr;
		mips_isa_pkg::alu_op_e alu_op;
		b_src_e b_src;
		logic shamt_sel;
		branch_e branch;
		logic mem_read;
		logic store_byte;
		logic store_word;
		logic reg_write;
		wb_sel_e wb_sel;
		logic [4:0] dst;
	} id_ex_t;

	// executed instruction entering MEM
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] alu_res;
		logic [`XLEN-1:0] rt_val;
		logic reg_write;
		wb_sel_e wb_sel;
		logic [4:0] dst;
		logic [`XLEN-1:0] link_addr;
	} ex_mem_t;

	typedef struct packed {
		logic en;
		logic [4:0] addr;
		logic [`XLEN-1:0] data;
	} rf_write_t;

	typedef struct packed {
		logic en;
		logic [`XLEN-1:0] addr;
	} imem_req_t;

	typedef struct packed {
		logic en;
		logic [3:0] wen;
		logic [`XLEN-1:0] addr;
		logic [`XLEN-1:0] wdata;
	} dmem_req_t;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [3:0] wen;
		logic [4:0] wnum;
		logic [`XLEN-1:0] wdata;
	} wb_trace_t;

endpackage

// File: design/mips_isa_pkg.sv
package mips_isa_pkg;

	// major opcodes, kept subset only
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_LBU     = 6'h24,
		OP_SB      = 6'h28,
		OP_SW      = 6'h2b
	} opcode_e;

	// funct field under OP_SPECIAL
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_e;

	// alu function select
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI
	} alu_op_e;

	typedef struct packed {
		opcode_e opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_e opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} i_fmt_t;

	typedef struct packed {
		opcode_e opcode;
		logic [25:0] target26;
	} j_fmt_t;

	// one instruction word, three field layouts
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		j_fmt_t j_fmt;
	} instr_u;

endpackage

// File: design/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// machine word and register file size
`define XLEN 32
`define NREGS 32

// first fetch address out of reset
`define BOOT_VECTOR 32'hbfc00000

// jal writes its return address here
`define LINK_REG 5'd31

`endif
